// ==== source/rvPkg.sv ====
package rvPkg;

    parameter int XLEN = 64;

    // RV64 major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OpcOp      = 7'b0110011,
        OpcOpImm   = 7'b0010011,
        OpcOp32    = 7'b0111011,
        OpcOpImm32 = 7'b0011011,
        OpcLui     = 7'b0110111,
        OpcAuipc   = 7'b0010111,
        OpcLoad    = 7'b0000011,
        OpcStore   = 7'b0100011,
        OpcJal     = 7'b1101111,
        OpcJalr    = 7'b1100111,
        OpcBranch  = 7'b1100011,
        OpcSystem  = 7'b1110011
    } opcodeE;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluMul,
        AluXor,
        AluOr,
        AluAnd,
        AluSll,
        AluSrl,
        AluSlt,
        AluSltu,
        AluRem,
        AluDivu,
        AluRemu,
        AluPassB, // lui
        AluNone
    } aluOpE;

    typedef enum logic [1:0] {
        WbAlu,
        WbLoad,
        WbLink,
        WbWord // low 32 bits of alu result, sign extended
    } wbSelE;

endpackage

// ==== source/ctrlIf.sv ====
interface ctrlIf;
    rvPkg::aluOpE aluOp;
    logic         selA;      // 1: rs1, 0: pc
    logic         selB;      // 1: rs2, 0: imm
    logic         wordOp;
    logic         writeRd;
    logic [7:0]   memWmask;
    logic         memRead;
    logic         loadSext;
    logic [3:0]   loadBytes;
    rvPkg::wbSelE wbSel;
    logic         pcSel;     // 1: jalr base
    logic         takeJump;
    logic         isEbreak;

    modport dec (output aluOp, selA, selB, wordOp, writeRd, memWmask, memRead, loadSext,
                 loadBytes, wbSel, pcSel, takeJump, isEbreak);
    modport alu (input aluOp, selA, selB, wordOp);
    modport lsu (input memWmask, memRead, loadSext, loadBytes, wbSel, writeRd);
    modport pcu (input pcSel, takeJump, isEbreak);
endinterface

// ==== source/instDecoder.sv ====
module instDecoder (
    input  logic [31:0]            inst,
    input  logic [rvPkg::XLEN-1:0] imm,
    input  logic [rvPkg::XLEN-1:0] rs1Data,
    input  logic [rvPkg::XLEN-1:0] rs2Data,
    ctrlIf.dec                     ctrl
);

    rvPkg::opcodeE opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;

    assign opcode = rvPkg::opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        ctrl.aluOp     = rvPkg::AluNone;
        ctrl.selA      = 1'b1;
        ctrl.selB      = 1'b1;
        ctrl.wordOp    = 1'b0;
        ctrl.writeRd   = 1'b0;
        ctrl.memWmask  = 8'h00;
        ctrl.memRead   = 1'b0;
        ctrl.loadSext  = 1'b0;
        ctrl.loadBytes = 4'd0;
        ctrl.wbSel     = rvPkg::WbAlu;
        ctrl.pcSel     = 1'b0;
        ctrl.takeJump  = 1'b0;
        ctrl.isEbreak  = 1'b0;
        case (opcode)
            rvPkg::OpcOp: begin
                case ({funct7, funct3})
                    {7'h00, 3'h0}: ctrl.aluOp = rvPkg::AluAdd;
                    {7'h20, 3'h0}: ctrl.aluOp = rvPkg::AluSub;
                    {7'h01, 3'h0}: ctrl.aluOp = rvPkg::AluMul;
                    {7'h00, 3'h4}: ctrl.aluOp = rvPkg::AluXor;
                    {7'h00, 3'h6}: ctrl.aluOp = rvPkg::AluOr;
                    {7'h00, 3'h7}: ctrl.aluOp = rvPkg::AluAnd;
                    {7'h00, 3'h1}: ctrl.aluOp = rvPkg::AluSll;
                    {7'h00, 3'h5}: ctrl.aluOp = rvPkg::AluSrl;
                    {7'h00, 3'h2}: ctrl.aluOp = rvPkg::AluSlt;
                    {7'h00, 3'h3}: ctrl.aluOp = rvPkg::AluSltu;
                    default:       ctrl.aluOp = rvPkg::AluNone;
                endcase
                ctrl.writeRd = ctrl.aluOp != rvPkg::AluNone;
            end
            rvPkg::OpcOpImm: begin
                ctrl.selB = 1'b0;
                case (funct3)
                    3'h0: ctrl.aluOp = rvPkg::AluAdd;
                    3'h4: ctrl.aluOp = rvPkg::AluXor;
                    3'h6: ctrl.aluOp = rvPkg::AluOr;
                    3'h7: ctrl.aluOp = rvPkg::AluAnd;
                    3'h2: ctrl.aluOp = rvPkg::AluSlt;
                    3'h3: ctrl.aluOp = rvPkg::AluSltu;
                    3'h1: ctrl.aluOp = (inst[31:26] == 6'd0) ? rvPkg::AluSll : rvPkg::AluNone;
                    default: ctrl.aluOp = (inst[31:26] == 6'd0) ? rvPkg::AluSrl : rvPkg::AluNone;
                endcase
                ctrl.writeRd = ctrl.aluOp != rvPkg::AluNone;
            end
            rvPkg::OpcOp32: begin
                ctrl.wordOp = 1'b1;
                ctrl.wbSel  = rvPkg::WbWord;
                case ({funct7, funct3})
                    {7'h00, 3'h0}: ctrl.aluOp = rvPkg::AluAdd;
                    {7'h20, 3'h0}: ctrl.aluOp = rvPkg::AluSub;
                    {7'h01, 3'h0}: ctrl.aluOp = rvPkg::AluMul;
                    {7'h01, 3'h6}: ctrl.aluOp = rvPkg::AluRem;
                    {7'h01, 3'h5}: ctrl.aluOp = rvPkg::AluDivu;
                    {7'h01, 3'h7}: ctrl.aluOp = rvPkg::AluRemu;
                    default:       ctrl.aluOp = rvPkg::AluNone;
                endcase
                ctrl.writeRd = ctrl.aluOp != rvPkg::AluNone;
            end
            rvPkg::OpcOpImm32: begin
                ctrl.selB    = 1'b0;
                ctrl.wordOp  = 1'b1;
                ctrl.wbSel   = rvPkg::WbWord;
                ctrl.aluOp   = (funct3 == 3'h0) ? rvPkg::AluAdd : rvPkg::AluNone; // addiw only
                ctrl.writeRd = funct3 == 3'h0;
            end
            rvPkg::OpcLui: begin
                ctrl.selB    = 1'b0;
                ctrl.aluOp   = rvPkg::AluPassB;
                ctrl.writeRd = 1'b1;
            end
            rvPkg::OpcAuipc: begin
                ctrl.selA    = 1'b0;
                ctrl.selB    = 1'b0;
                ctrl.aluOp   = rvPkg::AluAdd;
                ctrl.writeRd = 1'b1;
            end
            rvPkg::OpcLoad: begin
                ctrl.selB  = 1'b0;
                ctrl.wbSel = rvPkg::WbLoad;
                case (funct3)
                    3'h0: {ctrl.loadSext, ctrl.loadBytes} = {1'b1, 4'd1};
                    3'h1: {ctrl.loadSext, ctrl.loadBytes} = {1'b1, 4'd2};
                    3'h2: {ctrl.loadSext, ctrl.loadBytes} = {1'b1, 4'd4};
                    3'h3: {ctrl.loadSext, ctrl.loadBytes} = {1'b1, 4'd8};
                    3'h4: {ctrl.loadSext, ctrl.loadBytes} = {1'b0, 4'd1};
                    3'h5: {ctrl.loadSext, ctrl.loadBytes} = {1'b0, 4'd2};
                    default: {ctrl.loadSext, ctrl.loadBytes} = {1'b0, 4'd0};
                endcase
                ctrl.memRead = ctrl.loadBytes != 4'd0;
                ctrl.writeRd = ctrl.memRead;
                ctrl.aluOp   = ctrl.memRead ? rvPkg::AluAdd : rvPkg::AluNone;
            end
            rvPkg::OpcStore: begin
                ctrl.selB = 1'b0;
                case (funct3)
                    3'h0:    ctrl.memWmask = 8'h01;
                    3'h1:    ctrl.memWmask = 8'h03;
                    3'h2:    ctrl.memWmask = 8'h0f;
                    3'h3:    ctrl.memWmask = 8'hff;
                    default: ctrl.memWmask = 8'h00;
                endcase
                ctrl.aluOp = (ctrl.memWmask != 8'h00) ? rvPkg::AluAdd : rvPkg::AluNone;
            end
            rvPkg::OpcJal, rvPkg::OpcJalr: begin
                ctrl.pcSel    = opcode == rvPkg::OpcJalr;
                ctrl.takeJump = 1'b1;
                ctrl.writeRd  = 1'b1;
                ctrl.wbSel    = rvPkg::WbLink;
            end
            rvPkg::OpcBranch: begin
                case (funct3)
                    3'h0:    ctrl.takeJump = rs1Data == rs2Data;
                    3'h1:    ctrl.takeJump = rs1Data != rs2Data;
                    3'h4:    ctrl.takeJump = $signed(rs1Data) < $signed(rs2Data);
                    3'h5:    ctrl.takeJump = $signed(rs1Data) >= $signed(rs2Data);
                    3'h6:    ctrl.takeJump = rs1Data < rs2Data;
                    3'h7:    ctrl.takeJump = rs1Data >= rs2Data;
                    default: ctrl.takeJump = 1'b0;
                endcase
            end
            rvPkg::OpcSystem: begin
                // ebreak: imm 1 with rs1, funct3 and rd all zero
                ctrl.isEbreak = (imm == 64'd1) && (inst[19:7] == 13'd0);
            end
            default: ctrl.aluOp = rvPkg::AluNone;
        endcase
    end

endmodule

// ==== source/immGen.sv ====
module immGen (
    input  logic [31:0]            inst,
    output logic [rvPkg::XLEN-1:0] imm
);

    localparam int XLEN = rvPkg::XLEN;

    always_comb begin
        case (rvPkg::opcodeE'(inst[6:0]))
            rvPkg::OpcOpImm, rvPkg::OpcOpImm32, rvPkg::OpcLoad,
            rvPkg::OpcJalr, rvPkg::OpcSystem: begin
                imm = {{(XLEN-12){inst[31]}}, inst[31:20]};
            end
            rvPkg::OpcStore: begin
                imm = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            rvPkg::OpcBranch: begin // B type, bit 0 implied
                imm = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rvPkg::OpcLui, rvPkg::OpcAuipc: begin
                imm = {{(XLEN-32){inst[31]}}, inst[31:12], 12'd0};
            end
            rvPkg::OpcJal: begin
                imm = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== source/regFile.sv ====
module regFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [4:0]             rs1Addr,
    input  logic [4:0]             rs2Addr,
    input  logic [4:0]             rdAddr,
    input  logic [rvPkg::XLEN-1:0] rdData,
    input  logic                   rdWe,
    output logic [rvPkg::XLEN-1:0] rs1Data,
    output logic [rvPkg::XLEN-1:0] rs2Data
);

    logic [rvPkg::XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWe && (rdAddr != 5'd0)) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

// ==== source/execAlu.sv ====
module execAlu (
    ctrlIf.alu                     ctrl,
    input  logic [rvPkg::XLEN-1:0] pc,
    input  logic [rvPkg::XLEN-1:0] rs1Data,
    input  logic [rvPkg::XLEN-1:0] rs2Data,
    input  logic [rvPkg::XLEN-1:0] imm,
    output logic [rvPkg::XLEN-1:0] aluResult
);

    logic [rvPkg::XLEN-1:0]        opA, opB;
    logic [5:0]                    shAmt;
    logic [rvPkg::XLEN-1:0]        divA, divB, divBSafe, quotU, remU;
    logic [rvPkg::XLEN-1:0]        remA, remB, remBSafe;
    logic signed [rvPkg::XLEN-1:0] remS;

    always_comb begin
        opA   = ctrl.selA ? rs1Data : pc;
        opB   = ctrl.selB ? rs2Data : imm;
        shAmt = ctrl.wordOp ? {1'b0, opB[4:0]} : opB[5:0];
        divA  = ctrl.wordOp ? {32'd0, opA[31:0]} : opA; // unsigned operands
        divB  = ctrl.wordOp ? {32'd0, opB[31:0]} : opB;
        remA  = ctrl.wordOp ? {{32{opA[31]}}, opA[31:0]} : opA; // signed operands
        remB  = ctrl.wordOp ? {{32{opB[31]}}, opB[31:0]} : opB;
        // keep the dividers away from zero and the min / -1 overflow
        divBSafe = (divB == '0) ? 64'd1 : divB;
        remBSafe = ((remB == '0) || (remB == '1)) ? 64'd1 : remB;
        quotU    = divA / divBSafe;
        remU     = divA % divBSafe;
        remS     = $signed(remA) % $signed(remBSafe);
        case (ctrl.aluOp)
            rvPkg::AluAdd:   aluResult = opA + opB;
            rvPkg::AluSub:   aluResult = opA - opB;
            rvPkg::AluMul:   aluResult = opA * opB;
            rvPkg::AluXor:   aluResult = opA ^ opB;
            rvPkg::AluOr:    aluResult = opA | opB;
            rvPkg::AluAnd:   aluResult = opA & opB;
            rvPkg::AluSll:   aluResult = opA << shAmt;
            rvPkg::AluSrl:   aluResult = ctrl.wordOp ? {32'd0, opA[31:0] >> shAmt} : opA >> shAmt;
            rvPkg::AluSlt:   aluResult = {63'd0, $signed(opA) < $signed(opB)};
            rvPkg::AluSltu:  aluResult = {63'd0, opA < opB};
            rvPkg::AluDivu:  aluResult = (divB == '0) ? '1 : quotU;
            rvPkg::AluRemu:  aluResult = (divB == '0) ? divA : remU;
            rvPkg::AluRem:   aluResult = (remB == '0) ? remA : remS;
            rvPkg::AluPassB: aluResult = opB;
            default:         aluResult = '0;
        endcase
    end

endmodule

// ==== source/loadStore.sv ====
module loadStore (
    ctrlIf.lsu                     ctrl,
    input  logic                   halted,
    input  logic [rvPkg::XLEN-1:0] aluResult,
    input  logic [rvPkg::XLEN-1:0] rs2Data,
    input  logic [rvPkg::XLEN-1:0] linkAddr,
    input  logic [rvPkg::XLEN-1:0] memRdata,
    output logic [rvPkg::XLEN-1:0] memAddr,
    output logic [rvPkg::XLEN-1:0] memWdata,
    output logic [7:0]             memWmask,
    output logic                   memRead,
    output logic [rvPkg::XLEN-1:0] rdData,
    output logic                   rdWe
);

    logic [2:0]             offset;
    logic [rvPkg::XLEN-1:0] shifted, loadData;

    assign offset   = aluResult[2:0];
    assign memAddr  = aluResult;
    assign memWdata = rs2Data << {offset, 3'b000};
    assign memWmask = halted ? 8'h00 : ctrl.memWmask << offset;
    assign memRead  = ctrl.memRead;
    assign rdWe     = ctrl.writeRd && !halted;

    always_comb begin
        shifted = memRdata >> {offset, 3'b000}; // addressed byte to lane 0
        case (ctrl.loadBytes)
            4'd1: loadData = {{56{ctrl.loadSext & shifted[7]}}, shifted[7:0]};
            4'd2: loadData = {{48{ctrl.loadSext & shifted[15]}}, shifted[15:0]};
            4'd4: loadData = {{32{ctrl.loadSext & shifted[31]}}, shifted[31:0]};
            default: loadData = shifted;
        endcase
        case (ctrl.wbSel)
            rvPkg::WbLoad: rdData = loadData;
            rvPkg::WbLink: rdData = linkAddr;
            rvPkg::WbWord: rdData = {{32{aluResult[31]}}, aluResult[31:0]};
            default:       rdData = aluResult;
        endcase
    end

endmodule

// ==== source/pcUnit.sv ====
module pcUnit #(
    parameter logic [rvPkg::XLEN-1:0] ResetPc = '0
) (
    input  logic                   clk,
    input  logic                   arstN,
    ctrlIf.pcu                     ctrl,
    input  logic [rvPkg::XLEN-1:0] imm,
    input  logic [rvPkg::XLEN-1:0] rs1Data,
    output logic [rvPkg::XLEN-1:0] pc,
    output logic [rvPkg::XLEN-1:0] linkAddr,
    output logic                   halted
);

    logic [rvPkg::XLEN-1:0] jalrTarget, nextPc;

    assign linkAddr   = pc + 64'd4;
    assign jalrTarget = (rs1Data + imm) & ~64'd1;
    assign nextPc     = !ctrl.takeJump ? linkAddr : (ctrl.pcSel ? jalrTarget : pc + imm);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc     <= ResetPc;
            halted <= 1'b0;
        end else begin
            if (ctrl.isEbreak) halted <= 1'b1; // sticky until reset
            if (!halted && !ctrl.isEbreak) pc <= nextPc; // pc parks on the ebreak
        end
    end

endmodule

// ==== source/rvCore.sv ====
module rvCore #(
    parameter logic [rvPkg::XLEN-1:0] ResetPc = '0
) (
    input  logic                   clk,
    input  logic                   arstN,
    output logic [rvPkg::XLEN-1:0] pc,
    input  logic [31:0]            inst,
    output logic [rvPkg::XLEN-1:0] memAddr,
    output logic [rvPkg::XLEN-1:0] memWdata,
    output logic [7:0]             memWmask,
    output logic                   memRead,
    input  logic [rvPkg::XLEN-1:0] memRdata,
    output logic                   halt
);

    logic [rvPkg::XLEN-1:0] imm, rs1Data, rs2Data, aluResult, linkAddr, rdData;
    logic                   rdWe;

    ctrlIf ctrl ();

    instDecoder i_instDecoder (
        .inst(inst), .imm(imm), .rs1Data(rs1Data), .rs2Data(rs2Data), .ctrl(ctrl.dec)
    );

    immGen i_immGen (.inst(inst), .imm(imm));

    regFile i_regFile (
        .clk(clk), .arstN(arstN),
        .rs1Addr(inst[19:15]), .rs2Addr(inst[24:20]), .rdAddr(inst[11:7]),
        .rdData(rdData), .rdWe(rdWe), .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    execAlu i_execAlu (
        .ctrl(ctrl.alu), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
        .aluResult(aluResult)
    );

    loadStore i_loadStore (
        .ctrl(ctrl.lsu), .halted(halt), .aluResult(aluResult), .rs2Data(rs2Data),
        .linkAddr(linkAddr), .memRdata(memRdata), .memAddr(memAddr), .memWdata(memWdata),
        .memWmask(memWmask), .memRead(memRead), .rdData(rdData), .rdWe(rdWe)
    );

    pcUnit #(.ResetPc(ResetPc)) i_pcUnit (
        .clk(clk), .arstN(arstN), .ctrl(ctrl.pcu), .imm(imm), .rs1Data(rs1Data),
        .pc(pc), .linkAddr(linkAddr), .halted(halt)
    );

endmodule

// ==== dv/rvCoreTb.sv ====
module rvCoreTb;

    localparam logic [63:0] ResetPc = 64'h100;
    localparam logic [31:0] Nop     = 32'h00000013;
    localparam logic [31:0] Ebreak  = 32'h00100073;
    localparam logic [31:0] StoreX6 = {7'h20, 5'd6, 5'd0, 3'h3, 5'd0, 7'h23}; // sd x6, 0x400
    localparam logic [31:0] JalFwd  = {1'b0, 10'd4, 1'b0, 8'd0, 5'd1, 7'h6f}; // jal x1, +8

    logic        clk;
    logic        arstN;
    logic [63:0] pc, memAddr, memWdata, memRdata;
    logic [31:0] inst;
    logic [7:0]  memWmask;
    logic        memRead, halt;

    logic [31:0] rom [0:511];
    logic [63:0] expNext [0:511]; // next pc per rom slot
    logic [7:0]  expMask [0:511];
    logic [63:0] expData [0:511]; // store data, aligned and masked
    logic        expRead [0:511];
    logic [63:0] expAddr [0:511]; // load or store address
    logic [63:0] dmem [0:255];
    logic [63:0] cst [0:7];
    logic [63:0] xr [0:31];       // reference register model
    logic [63:0] sp;
    int          n, errors, timeouts, cycles;
    logic [8:0]  pcIdx;
    logic [63:0] expNextPc, expDataNow, expBits, expAddrNow;
    logic [7:0]  expMaskNow;
    logic        expReadNow;

    rvCore #(.ResetPc(ResetPc)) i_rvCore (
        .clk(clk), .arstN(arstN), .pc(pc), .inst(inst), .memAddr(memAddr),
        .memWdata(memWdata), .memWmask(memWmask), .memRead(memRead),
        .memRdata(memRdata), .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign memRdata   = memRead ? dmem[memAddr[10:3]] : '0;
    assign pcIdx      = 9'((pc - ResetPc) >> 2);
    assign expNextPc  = expNext[pcIdx];
    assign expMaskNow = expMask[pcIdx];
    assign expDataNow = expData[pcIdx];
    assign expReadNow = expRead[pcIdx];
    assign expAddrNow = expAddr[pcIdx];
    assign expBits    = bytesOf(expMaskNow);

    always @(posedge clk) begin
        for (int b = 0; b < 8; b++) begin
            if (arstN && memWmask[b]) dmem[memAddr[10:3]][8*b +: 8] <= memWdata[8*b +: 8];
        end
    end

    task automatic flagError(string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    resetState: assert property (@(posedge clk)
        $rose(arstN) |-> pc == ResetPc && !halt && memWmask == 8'h00)
        else flagError("wrong pc, halt or memWmask after reset");
    nextPc: assert property (@(posedge clk) disable iff (!arstN)
        !halt |=> pc == $past(expNextPc))
        else flagError("pc differs from the next-pc rule");
    storeCheck: assert property (@(posedge clk) disable iff (!arstN)
        !halt |-> memWmask == expMaskNow && (memWdata & expBits) == expDataNow)
        else flagError("store mask or data differs from the register model");
    memAccess: assert property (@(posedge clk) disable iff (!arstN)
        !halt |-> memRead == expReadNow &&
        (!(expReadNow || expMaskNow != 8'h00) || memAddr == expAddrNow))
        else flagError("memRead or memAddr differs from the instruction");
    haltRise: assert property (@(posedge clk) disable iff (!arstN)
        (inst == Ebreak && !halt) |=> halt)
        else flagError("halt did not rise after ebreak");
    haltHold: assert property (@(posedge clk) disable iff (!arstN)
        halt |=> halt && $stable(pc) && memWmask == 8'h00)
        else flagError("core moved while halted");

    function automatic logic [63:0] bytesOf(logic [7:0] mask);
        logic [63:0] bits;
        for (int b = 0; b < 8; b++) bits[8*b +: 8] = {8{mask[b]}};
        return bits;
    endfunction

    function automatic logic [63:0] pcOf(int idx);
        return ResetPc + 64'(idx) * 64'd4;
    endfunction

    function automatic logic [63:0] refAlu(string op, logic [63:0] a, logic [63:0] b);
        logic [31:0]        w;
        logic signed [63:0] sa, sb;
        sa = $signed({{32{a[31]}}, a[31:0]});
        sb = $signed({{32{b[31]}}, b[31:0]});
        case (op)
            "add":   return a + b;
            "sub":   return a - b;
            "mul":   return a * b;
            "xor":   return a ^ b;
            "or":    return a | b;
            "and":   return a & b;
            "sll":   return a << b[5:0];
            "srl":   return a >> b[5:0];
            "slt":   return {63'd0, $signed(a) < $signed(b)};
            "sltu":  return {63'd0, a < b};
            "addw":  w = a[31:0] + b[31:0];
            "subw":  w = a[31:0] - b[31:0];
            "mulw":  w = a[31:0] * b[31:0];
            "remw":  w = (sb == 0) ? a[31:0] : 32'(sa % sb);
            "divuw": w = (b[31:0] == 0) ? '1 : a[31:0] / b[31:0];
            "remuw": w = (b[31:0] == 0) ? a[31:0] : a[31:0] % b[31:0];
            default: w = '0;
        endcase
        return {{32{w[31]}}, w}; // word results sign extend
    endfunction

    task automatic emit(logic [31:0] word);
        rom[n] = word;
        expNext[n] = pcOf(n) + 64'd4;
        expMask[n] = 8'h00;
        expData[n] = '0;
        expRead[n] = 1'b0;
        expAddr[n] = '0;
        n++;
    endtask

    task automatic setReg(int rd, logic [63:0] value);
        if (rd != 0) xr[rd] = value;
    endtask

    task automatic regOp(string op, int rd, int rs1, int rs2);
        logic [6:0] f7, opc;
        logic [2:0] f3;
        f7  = 7'h00;
        opc = 7'h33;
        case (op)
            "add":   f3 = 3'h0;
            "sub":   {f7, f3} = {7'h20, 3'h0};
            "mul":   {f7, f3} = {7'h01, 3'h0};
            "xor":   f3 = 3'h4;
            "or":    f3 = 3'h6;
            "and":   f3 = 3'h7;
            "sll":   f3 = 3'h1;
            "srl":   f3 = 3'h5;
            "slt":   f3 = 3'h2;
            "sltu":  f3 = 3'h3;
            "addw":  {opc, f3} = {7'h3b, 3'h0};
            "subw":  {opc, f7, f3} = {7'h3b, 7'h20, 3'h0};
            "mulw":  {opc, f7, f3} = {7'h3b, 7'h01, 3'h0};
            "remw":  {opc, f7, f3} = {7'h3b, 7'h01, 3'h6};
            "divuw": {opc, f7, f3} = {7'h3b, 7'h01, 3'h5};
            default: {opc, f7, f3} = {7'h3b, 7'h01, 3'h7}; // remuw
        endcase
        emit({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc});
        setReg(rd, refAlu(op, xr[rs1], xr[rs2]));
    endtask

    task automatic immOp(string op, int rd, int rs1, logic [11:0] imm);
        logic [2:0] f3;
        case (op)
            "xor":   f3 = 3'h4;
            "or":    f3 = 3'h6;
            "and":   f3 = 3'h7;
            "sll":   f3 = 3'h1;
            "srl":   f3 = 3'h5;
            "slt":   f3 = 3'h2;
            "sltu":  f3 = 3'h3;
            default: f3 = 3'h0; // add, addw
        endcase
        emit({imm, 5'(rs1), f3, 5'(rd), (op == "addw") ? 7'h1b : 7'h13});
        setReg(rd, refAlu(op, xr[rs1], {{52{imm[11]}}, imm}));
    endtask

    task automatic load(logic [2:0] f3, int rd, logic [11:0] addr);
        logic [63:0] sh;
        sh = cst[addr[5:3]] >> {addr[2:0], 3'b000};
        emit({addr, 5'd0, f3, 5'(rd), 7'h03});
        expRead[n-1] = 1'b1;
        expAddr[n-1] = {{52{addr[11]}}, addr};
        case (f3)
            3'h0:    setReg(rd, {{56{sh[7]}}, sh[7:0]});
            3'h1:    setReg(rd, {{48{sh[15]}}, sh[15:0]});
            3'h2:    setReg(rd, {{32{sh[31]}}, sh[31:0]});
            3'h4:    setReg(rd, {56'd0, sh[7:0]});
            3'h5:    setReg(rd, {48'd0, sh[15:0]});
            default: setReg(rd, sh);
        endcase
    endtask

    task automatic store(logic [2:0] f3, int rs2, logic [11:0] addr);
        logic [7:0] mask;
        emit({addr[11:5], 5'(rs2), 5'd0, f3, addr[4:0], 7'h23});
        mask = 8'((16'd1 << (4'd1 << f3)) - 16'd1) << addr[2:0];
        expMask[n-1] = mask;
        expData[n-1] = (xr[rs2] << {addr[2:0], 3'b000}) & bytesOf(mask);
        expAddr[n-1] = {{52{addr[11]}}, addr};
    endtask

    task automatic storeResult(int rs2);
        store(3'h3, rs2, sp[11:0]);
        sp += 64'd8;
    endtask

    task automatic branch(logic [2:0] f3, int rs1, int rs2);
        logic [63:0] a, b;
        logic        taken;
        a = xr[rs1];
        b = xr[rs2];
        case (f3)
            3'h0:    taken = a == b;
            3'h1:    taken = a != b;
            3'h4:    taken = $signed(a) < $signed(b);
            3'h5:    taken = $signed(a) >= $signed(b);
            3'h6:    taken = a < b;
            default: taken = a >= b;
        endcase
        emit({1'b0, 6'd0, 5'(rs2), 5'(rs1), f3, 4'd4, 1'b0, 7'h63}); // offset +8
        if (taken) expNext[n-1] = pcOf(n-1) + 64'd8;
        emit(Nop); // skipped when taken
    endtask

    task automatic buildProgram();
        string      rrOps [16] = '{"add", "sub", "mul", "xor", "or", "and", "sll", "srl",
                                   "slt", "sltu", "addw", "subw", "mulw", "remw", "divuw",
                                   "remuw"};
        string      riOps [9]  = '{"add", "xor", "or", "and", "slt", "sltu", "sll", "srl",
                                   "addw"};
        logic [2:0] brF3 [6]   = '{3'h0, 3'h1, 3'h4, 3'h5, 3'h6, 3'h7};
        logic [11:0] jImm;
        logic [19:0] u;
        for (int i = 1; i <= 8; i++) load(3'h3, i, 12'(8 * (i - 1)));
        foreach (rrOps[k]) begin
            for (int p = 0; p < 3; p++) begin
                regOp(rrOps[k], 20, 2 * p + 1, (p == 2) ? 0 : 2 * p + 2); // x5 by x0 last
                storeResult(20);
            end
        end
        foreach (riOps[k]) begin
            if (riOps[k] == "sll" || riOps[k] == "srl") begin
                immOp(riOps[k], 20, 6, {6'd0, 6'($urandom)});
            end else begin
                immOp(riOps[k], 20, 6, 12'($urandom));
            end
            storeResult(20);
        end
        for (int off = 0; off < 8; off++) begin
            for (int f = 0; f < 6; f++) begin // lb lh lw ld lbu lhu
                if (off % (1 << (f % 4)) == 0) begin
                    load(3'(f), 21, 12'(8 + off));
                    storeResult(21);
                end
            end
        end
        for (int f = 0; f < 4; f++) begin
            for (int off = 0; off < 8; off += (1 << f)) store(3'(f), 6, 12'(sp + 64'(off)));
        end
        sp += 64'd8;
        immOp("add", 21, 0, 12'hfff);
        immOp("add", 22, 0, 12'h001);
        foreach (brF3[k]) begin
            branch(brF3[k], 21, 22);
            branch(brF3[k], 22, 21);
            branch(brF3[k], 22, 22);
        end
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd23, 7'h6f}); // jal x23, +8
        expNext[n-1] = pcOf(n-1) + 64'd8;
        setReg(23, pcOf(n-1) + 64'd4);
        emit(Nop);
        storeResult(23);
        emit({20'd0, 5'd24, 7'h17}); // auipc x24, 0
        setReg(24, pcOf(n-1));
        jImm = 12'(pcOf(n) + 64'd9 - xr[24]); // odd target, bit 0 gets cleared
        emit({jImm, 5'd24, 3'h0, 5'd25, 7'h67});
        expNext[n-1] = (xr[24] + {{52{jImm[11]}}, jImm}) & ~64'd1;
        setReg(25, pcOf(n-1) + 64'd4);
        emit(Nop);
        storeResult(25);
        u = 20'($urandom);
        emit({u, 5'd26, 7'h37});
        setReg(26, {{32{u[19]}}, u, 12'd0});
        storeResult(26);
        immOp("add", 0, 6, 12'd77); // writes to x0
        storeResult(0);
        regOp("add", 0, 1, 2);
        storeResult(0);
        load(3'h3, 0, 12'd0);
        storeResult(0);
        emit(Ebreak);
        expNext[n-1] = pcOf(n-1); // pc parks on ebreak
    endtask

    initial begin
        void'($urandom(32'hda0d3373));
        errors   = 0;
        timeouts = 0;
        n        = 0;
        sp       = 64'h400;
        arstN    = 1'b0;
        inst     = Nop;
        for (int i = 0; i < 32; i++) xr[i] = '0;
        for (int i = 0; i < 256; i++) dmem[i] = {32'(i) * 32'h9e3779b9, ~32'(i * 8)};
        for (int i = 0; i < 512; i++) begin
            rom[i]     = Nop;
            expNext[i] = pcOf(i) + 64'd4;
            expMask[i] = 8'h00;
            expData[i] = '0;
            expRead[i] = 1'b0;
            expAddr[i] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            cst[i]  = {$urandom, $urandom};
            dmem[i] = cst[i];
        end
        buildProgram();
        repeat (5) @(negedge clk);
        arstN = 1'b1;
        inst  = rom[pcIdx];
        cycles = 0;
        while (!halt && cycles < 2000) begin
            @(negedge clk);
            inst = rom[pcIdx];
            cycles++;
        end
        if (!halt) begin
            timeouts++;
            $display("timed out waiting for halt");
        end else begin
            for (int i = 0; i < 20; i++) begin // halted window, stores and jumps offered
                @(negedge clk);
                inst = (i % 2 == 0) ? StoreX6 : JalFwd;
            end
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
source/rvPkg.sv
source/ctrlIf.sv
source/instDecoder.sv
source/immGen.sv
source/regFile.sv
source/execAlu.sv
source/loadStore.sv
source/pcUnit.sv
source/rvCore.sv
dv/rvCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= rvCoreTb
RTL_TOP   ?= rvCore
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
